// File: files.f
+incdir+include
hdl/i2c_pkg.sv
hdl/i2c_cmd_stage.sv
hdl/i2c_byte_sequencer.sv
hdl/i2c_bit_engine.sv
hdl/i2c_read_collector.sv
hdl/i2c_nbyte_master.sv
verification/i2c_eeprom_model.sv
verification/tb_i2c_nbyte_master.sv

// File: Bender.yml
package:
  name: i2c_nbyte_master

sources:
  - include_dirs:
      - include
    files:
      - hdl/i2c_pkg.sv
      - hdl/i2c_cmd_stage.sv
      - hdl/i2c_byte_sequencer.sv
      - hdl/i2c_bit_engine.sv
      - hdl/i2c_read_collector.sv
      - hdl/i2c_nbyte_master.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/i2c_eeprom_model.sv
      - verification/tb_i2c_nbyte_master.sv

// File: verification/tb_i2c_nbyte_master.sv
// I2C multi-byte master testbench
`include "i2c_cfg.svh"

module tb_i2c_nbyte_master;

	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		i2c_pkg::i2c_cmd_t    command;
		i2c_pkg::i2c_dev_id_t dev_id;
		i2c_pkg::i2c_byte_t   word_addr;
		i2c_pkg::i2c_count_t  byte_cnt;
		logic                 write_protect;
		logic                 exp_fail;
		logic                 poke;       // extra write strobe while busy
	} stim_row_t;

	localparam i2c_pkg::i2c_cmd_t cmd_wr = 2'b10;
	localparam i2c_pkg::i2c_cmd_t cmd_rd = 2'b01;

	// command, dev_id, word_addr, byte_cnt, write_protect, exp_fail, poke
	stim_row_t rows [20] = '{
		{cmd_wr, 7'h50, 8'h10, 3'd1, 1'b0, 1'b0, 1'b0},
		{cmd_rd, 7'h50, 8'h10, 3'd1, 1'b0, 1'b0, 1'b0},
		{cmd_wr, 7'h50, 8'h20, 3'd2, 1'b0, 1'b0, 1'b0},
		{cmd_rd, 7'h50, 8'h20, 3'd2, 1'b0, 1'b0, 1'b0},
		{cmd_wr, 7'h50, 8'h30, 3'd3, 1'b0, 1'b0, 1'b0},
		{cmd_rd, 7'h50, 8'h30, 3'd3, 1'b0, 1'b0, 1'b0},
		{cmd_wr, 7'h50, 8'h40, 3'd4, 1'b0, 1'b0, 1'b0},
		{cmd_rd, 7'h50, 8'h40, 3'd4, 1'b0, 1'b0, 1'b0},
		{cmd_wr, 7'h50, 8'h50, 3'd5, 1'b0, 1'b0, 1'b0},
		{cmd_rd, 7'h50, 8'h50, 3'd5, 1'b0, 1'b0, 1'b0},
		{cmd_wr, 7'h50, 8'h60, 3'd6, 1'b0, 1'b0, 1'b0},
		{cmd_rd, 7'h50, 8'h60, 3'd6, 1'b0, 1'b0, 1'b0},
		{cmd_wr, 7'h50, 8'h30, 3'd3, 1'b1, 1'b1, 1'b0},  // protected write leaves the bus idle
		{cmd_rd, 7'h50, 8'h30, 3'd3, 1'b0, 1'b0, 1'b0},
		{cmd_rd, 7'h51, 8'h30, 3'd3, 1'b0, 1'b1, 1'b0},  // wrong slave
		{cmd_wr, 7'h2a, 8'h40, 3'd2, 1'b0, 1'b1, 1'b0},
		{cmd_rd, 7'h50, 8'h40, 3'd4, 1'b0, 1'b0, 1'b0},
		{cmd_wr, 7'h50, 8'h70, 3'd4, 1'b0, 1'b0, 1'b1},
		{cmd_rd, 7'h50, 8'h70, 3'd4, 1'b0, 1'b0, 1'b1},
		{cmd_rd, 7'h50, 8'h10, 3'd6, 1'b0, 1'b0, 1'b0}
	};

	logic                  clk;
	logic                  rst_n;
	i2c_pkg::i2c_cmd_t     command;
	i2c_pkg::i2c_dev_id_t  dev_id;
	i2c_pkg::i2c_byte_t    word_addr;
	i2c_pkg::i2c_payload_t wdata;
	i2c_pkg::i2c_count_t   byte_cnt;
	logic                  write_protect;
	logic                  busy;
	logic                  fail;
	i2c_pkg::i2c_payload_t rdata;
	logic                  scl;
	wire                   sda;
	i2c_pkg::i2c_byte_t    sb [256];    // expected slave memory
	logic [31:0]           lcg_state;

	i2c_nbyte_master u_dut (
		.clk, .rst_n, .command, .dev_id, .word_addr, .wdata, .byte_cnt,
		.write_protect, .busy, .fail, .rdata, .scl, .sda
	);

	pullup (sda);

	i2c_eeprom_model u_eeprom (.scl(scl), .sda(sda));

	always #5 clk = ~clk;

	// **************************************************
	// stimulus helpers
	// **************************************************
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic make_payload(output i2c_pkg::i2c_payload_t p);
		p = '0;
		for (int k = 0; k < `I2C_MAX_BYTES; k++)
		begin
			lcg_state = lcg_next(lcg_state);
			p[8*k +: 8] = lcg_state[23:16];
		end
	endtask

	// byte count-1 goes out first and the slave pointer counts up
	task automatic record_write(input i2c_pkg::i2c_byte_t addr, input int n,
		input i2c_pkg::i2c_payload_t p);
		for (int j = 0; j < n; j++)
			sb[8'(addr + j)] = p[8*(n - 1 - j) +: 8];
	endtask

	// last byte read lands in bits 7:0
	function automatic i2c_pkg::i2c_payload_t expected_read(input i2c_pkg::i2c_byte_t addr,
		input int n);
		i2c_pkg::i2c_payload_t e;
		e = '0;
		for (int k = 0; k < n; k++)
			e[8*k +: 8] = sb[8'(addr + n - 1 - k)];
		return e;
	endfunction

	task automatic check_payload(input i2c_pkg::i2c_payload_t got,
		input i2c_pkg::i2c_payload_t exp, input string what);
		if (got !== exp)
		begin
			$display("[ERROR] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("[ERROR] %0t ns: %s, got %b, expected %b", $time, what, got, exp);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic wait_idle(input int idx);
		int cycles;
		cycles = 0;
		while (busy === 1'b1 && cycles < 20000)
		begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (busy !== 1'b0)
		begin
			$display("row %0d: the transfer never finished, busy still high", idx);
			$display("test failed");
			$fatal(1);
		end
	endtask

	// **************************************************
	// one table row
	// **************************************************
	task automatic run_row(input int idx, input stim_row_t r);
		i2c_pkg::i2c_payload_t pay;
		i2c_pkg::i2c_payload_t extra;
		logic                  wr;
		wr  = r.command[1];   // write wins
		pay = '0;
		if (wr)
			make_payload(pay);
		@(posedge clk);
		#1;
		command       = r.command;
		dev_id        = r.dev_id;
		word_addr     = r.word_addr;
		byte_cnt      = r.byte_cnt;
		wdata         = pay;
		write_protect = r.write_protect;
		@(posedge clk);
		#1;
		command       = '0;
		write_protect = 1'b0;
		if (wr && r.write_protect)
		begin
			check_flag(busy, 1'b0, $sformatf("row %0d busy on protected write", idx));
			check_flag(fail, r.exp_fail, $sformatf("row %0d fail on protected write", idx));
		end
		else
		begin
			check_flag(busy, 1'b1, $sformatf("row %0d busy after strobe", idx));
			if (r.poke)
			begin
				make_payload(extra);
				command = cmd_wr;
				wdata   = extra;
				@(posedge clk);
				#1;
				command = '0;
			end
			wait_idle(idx);
			check_flag(fail, r.exp_fail, $sformatf("row %0d fail at end", idx));
			if (!r.exp_fail && wr)
				record_write(r.word_addr, int'(r.byte_cnt), pay);
			else if (!r.exp_fail)
				check_payload(rdata, expected_read(r.word_addr, int'(r.byte_cnt)),
					$sformatf("row %0d read data", idx));
		end
	endtask

	initial
	begin
		clk           = 1'b0;
		rst_n         = 1'b0;
		command       = '0;
		dev_id        = '0;
		word_addr     = '0;
		wdata         = '0;
		byte_cnt      = '0;
		write_protect = 1'b0;
		lcg_state     = 32'd43;
		for (int i = 0; i < 256; i++)
			sb[i] = 8'(i) ^ 8'h5a;   // slave power-up contents
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_flag(busy, 1'b0, "busy after reset");
		check_flag(fail, 1'b0, "fail after reset");
		check_flag(scl, 1'b1, "scl after reset");
		check_flag(sda, 1'b1, "sda after reset");
		check_payload(rdata, '0, "rdata after reset");
		foreach (rows[i])
			run_row(i, rows[i]);
		$display("test passed");
		$finish;
	end

endmodule

// File: verification/i2c_eeprom_model.sv
// EEPROM slave model
module i2c_eeprom_model (
	input  logic scl,
	inout  wire  sda
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [6:0] own_addr = 7'h50;

	typedef enum logic [2:0] {sl_idle, sl_dev, sl_word, sl_wdata, sl_rdata} slave_state_e;

	i2c_pkg::i2c_byte_t mem [256];
	i2c_pkg::i2c_byte_t ptr;          // auto-increment pointer
	i2c_pkg::i2c_byte_t rx_sh;
	i2c_pkg::i2c_byte_t tx_sh;
	slave_state_e       state;
	int                 bit_no;       // rising scl edges in this byte
	logic               rd_mode;
	logic               master_nack;
	logic               sda_drv;

	assign sda = sda_drv ? 1'b0 : 1'bz;

	initial
	begin
		for (int i = 0; i < 256; i++)
			mem[i] = 8'(i) ^ 8'h5a;
		ptr         = '0;
		rx_sh       = '0;
		tx_sh       = '0;
		state       = sl_idle;
		bit_no      = 0;
		rd_mode     = 1'b0;
		master_nack = 1'b1;
		sda_drv     = 1'b0;
	end

	// **************************************************
	// start and stop, sda moving while scl high
	// **************************************************
	always @(negedge sda)
	begin
		if (scl === 1'b1)
		begin
			state  = sl_dev;
			bit_no = 0;
		end
	end

	always @(posedge sda)
	begin
		if (scl === 1'b1)
			state = sl_idle;
	end

	always @(posedge scl)
	begin
		if (state != sl_idle)
		begin
			if (bit_no < 8)
				rx_sh = {rx_sh[6:0], sda};
			else
				master_nack = sda;   // ack slot of a read byte
			bit_no++;
		end
	end

	task automatic end_of_byte();
		logic ack;
		ack = 1'b1;
		case (state)
			sl_dev:
				if (rx_sh[7:1] == own_addr)
					rd_mode = rx_sh[0];
				else
				begin
					ack   = 1'b0;
					state = sl_idle;   // not ours
				end
			sl_word:
				ptr = rx_sh;
			sl_wdata:
			begin
				mem[ptr] = rx_sh;
				ptr++;
			end
			default:
				ack = 1'b0;   // master owns this ack slot
		endcase
		sda_drv <= #1 ack;
	endtask

	task automatic start_of_byte();
		bit_no = 0;
		case (state)
			sl_dev:
				state = rd_mode ? sl_rdata : sl_word;
			sl_word:
				state = sl_wdata;
			sl_rdata:
				if (master_nack)
					state = sl_idle;
			default:
				;
		endcase
		if (state == sl_rdata)
		begin
			tx_sh = mem[ptr];
			ptr++;
			sda_drv <= #1 !tx_sh[7];
		end
		else
			sda_drv <= #1 1'b0;
	endtask

	// drive changes 1 ns after scl falls
	always @(negedge scl)
	begin
		if (state != sl_idle && bit_no == 8)
			end_of_byte();
		else if (state != sl_idle && bit_no == 9)
			start_of_byte();
		else if (state == sl_rdata && bit_no > 0)
			sda_drv <= #1 !tx_sh[7 - bit_no];
	end

endmodule

// File: hdl/i2c_nbyte_master.sv
// I2C multi-byte master
module i2c_nbyte_master (
	input  logic                   clk,
	input  logic                   rst_n,
	input  i2c_pkg::i2c_cmd_t      command,
	input  i2c_pkg::i2c_dev_id_t   dev_id,
	input  i2c_pkg::i2c_byte_t     word_addr,
	input  i2c_pkg::i2c_payload_t  wdata,
	input  i2c_pkg::i2c_count_t    byte_cnt,
	input  logic                   write_protect,
	output logic                   busy,
	output logic                   fail,
	output i2c_pkg::i2c_payload_t  rdata,
	output logic                   scl,
	inout  wire                    sda
);

	i2c_pkg::i2c_req_t    req;
	i2c_pkg::i2c_op_t     op;
	i2c_pkg::i2c_op_rsp_t rsp;
	logic                 req_valid;
	logic                 xfer_done;
	logic                 xfer_nack;
	logic                 op_start;
	logic                 op_done;
	logic                 rx_strobe;
	logic                 clear;
	logic                 sda_oe;
	logic                 sda_in;

	// open drain, pulled up on the board
	assign sda    = sda_oe ? 1'b0 : 1'bz;
	assign sda_in = sda;

	i2c_cmd_stage u_cmd (
		.clk, .rst_n, .command, .dev_id, .word_addr, .wdata, .byte_cnt,
		.write_protect, .xfer_done, .xfer_nack, .req, .req_valid, .busy, .fail
	);

	i2c_byte_sequencer u_seq (
		.clk, .rst_n, .req, .req_valid, .op_done, .rsp,
		.op, .op_start, .rx_strobe, .clear, .xfer_done, .xfer_nack
	);

	i2c_bit_engine u_bit (
		.clk, .rst_n, .op, .op_start, .sda_in, .op_done, .rsp, .scl, .sda_oe
	);

	i2c_read_collector u_rd (
		.clk, .rst_n, .clear, .rx_strobe, .rx_byte(rsp.rx_byte), .rdata
	);

endmodule

// File: hdl/i2c_read_collector.sv
// I2C read data collector
`include "i2c_cfg.svh"

module i2c_read_collector (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   clear,
	input  logic                   rx_strobe,
	input  i2c_pkg::i2c_byte_t     rx_byte,
	output i2c_pkg::i2c_payload_t  rdata
);

	// **************************************************
	// byte assembly
	// **************************************************

	// first byte ends up highest, last byte in bits 7:0
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rdata <= '0;
		else if (clear)
			rdata <= '0;   // new read starts from zero
		else if (rx_strobe)
			rdata <= {rdata[`I2C_PAYLOAD_W-9:0], rx_byte};
	end

endmodule

// File: hdl/i2c_bit_engine.sv
// I2C bit engine
`include "i2c_cfg.svh"

module i2c_bit_engine (
	input  logic                  clk,
	input  logic                  rst_n,
	input  i2c_pkg::i2c_op_t      op,
	input  logic                  op_start,
	input  logic                  sda_in,
	output logic                  op_done,
	output i2c_pkg::i2c_op_rsp_t  rsp,
	output logic                  scl,
	output logic                  sda_oe
);

	localparam int tick_w = $clog2(`I2C_TICK_DIV);

	i2c_pkg::i2c_bit_phase_e phase;
	logic [tick_w-1:0]       tick;
	logic [2:0]              bit_cnt;
	i2c_pkg::i2c_byte_t      shreg;     // tx bits out of [7], rx bits into [0]
	logic                    is_recv;
	logic                    ack_lvl;
	logic                    half_end;

	assign half_end = (phase != i2c_pkg::ph_idle) && (tick == tick_w'(`I2C_TICK_DIV - 1));

	// half period divider
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			tick <= '0;
		else if (op_start || half_end)
			tick <= '0;
		else if (phase != i2c_pkg::ph_idle)
			tick <= tick + 1'b1;
	end

	// **************************************************
	// phase walk, SDA only moves while SCL is low
	// **************************************************
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			phase   <= i2c_pkg::ph_idle;
			bit_cnt <= '0;
			shreg   <= '0;
			is_recv <= 1'b0;
			ack_lvl <= 1'b1;
			scl     <= 1'b1;
			sda_oe  <= 1'b0;
			op_done <= 1'b0;
			rsp     <= '0;
		end
		else
		begin
			op_done <= 1'b0;
			if (op_start)
			begin
				bit_cnt <= '0;
				shreg   <= op.data;
				is_recv <= (op.op == i2c_pkg::op_recv);
				ack_lvl <= op.ack_out;
				case (op.op)
					i2c_pkg::op_start:
					begin
						phase  <= i2c_pkg::ph_start_a;
						scl    <= 1'b1;
						sda_oe <= 1'b0;
					end
					i2c_pkg::op_stop:
					begin
						phase  <= i2c_pkg::ph_stop_a;
						scl    <= 1'b0;
						sda_oe <= 1'b1;
					end
					default:
					begin
						phase  <= i2c_pkg::ph_bit_lo;
						scl    <= 1'b0;
						sda_oe <= (op.op == i2c_pkg::op_send) && !op.data[7];
					end
				endcase
			end
			else if (half_end)
			begin
				case (phase)
					i2c_pkg::ph_start_a:
					begin
						phase  <= i2c_pkg::ph_start_b;
						sda_oe <= 1'b1;   // start condition
					end
					i2c_pkg::ph_start_b:
					begin
						phase   <= i2c_pkg::ph_idle;
						scl     <= 1'b0;
						op_done <= 1'b1;
					end
					i2c_pkg::ph_stop_a:
					begin
						phase <= i2c_pkg::ph_stop_b;
						scl   <= 1'b1;
					end
					i2c_pkg::ph_stop_b:
					begin
						phase   <= i2c_pkg::ph_idle;
						sda_oe  <= 1'b0;  // stop condition
						op_done <= 1'b1;
					end
					i2c_pkg::ph_bit_lo:
					begin
						phase <= i2c_pkg::ph_bit_hi;
						scl   <= 1'b1;
						shreg <= {shreg[6:0], sda_in};  // rising edge sample
					end
					i2c_pkg::ph_bit_hi:
					begin
						scl <= 1'b0;
						if (bit_cnt == 3'd7)
						begin
							phase  <= i2c_pkg::ph_ack_lo;
							sda_oe <= is_recv && !ack_lvl;
						end
						else
						begin
							phase   <= i2c_pkg::ph_bit_lo;
							bit_cnt <= bit_cnt + 3'd1;
							sda_oe  <= !is_recv && !shreg[7];
						end
					end
					i2c_pkg::ph_ack_lo:
					begin
						phase    <= i2c_pkg::ph_ack_hi;
						scl      <= 1'b1;
						rsp.nack <= sda_in;
					end
					i2c_pkg::ph_ack_hi:
					begin
						phase       <= i2c_pkg::ph_idle;
						scl         <= 1'b0;
						rsp.rx_byte <= shreg;
						op_done     <= 1'b1;
					end
					default:
						phase <= i2c_pkg::ph_idle;
				endcase
			end
		end
	end

endmodule

// File: hdl/i2c_byte_sequencer.sv
// I2C transaction sequencer
module i2c_byte_sequencer (
	input  logic                  clk,
	input  logic                  rst_n,
	input  i2c_pkg::i2c_req_t     req,
	input  logic                  req_valid,
	input  logic                  op_done,
	input  i2c_pkg::i2c_op_rsp_t  rsp,
	output i2c_pkg::i2c_op_t      op,
	output logic                  op_start,
	output logic                  rx_strobe,
	output logic                  clear,
	output logic                  xfer_done,
	output logic                  xfer_nack
);

	i2c_pkg::i2c_seq_state_e state;
	i2c_pkg::i2c_count_t     cnt;       // bytes left after the one in flight
	i2c_pkg::i2c_count_t     wr_sel;
	i2c_pkg::i2c_byte_t      wr_byte;
	logic                    send_state;

	function automatic i2c_pkg::i2c_op_t make_op(input i2c_pkg::i2c_op_e kind,
		input i2c_pkg::i2c_byte_t data, input logic ack);
		i2c_pkg::i2c_op_t o;
		o.op      = kind;
		o.data    = data;
		o.ack_out = ack;
		return o;
	endfunction

	// highest byte goes out first
	assign wr_sel  = (state == i2c_pkg::seq_word) ? req.count - 3'd1 : cnt - 3'd1;
	assign wr_byte = req.wdata[{wr_sel, 3'b000} +: 8];

	// states whose ack slot belongs to the slave
	assign send_state = (state == i2c_pkg::seq_dev_w) || (state == i2c_pkg::seq_word) ||
		(state == i2c_pkg::seq_wdata) || (state == i2c_pkg::seq_dev_r);

	assign rx_strobe = op_done && (state == i2c_pkg::seq_rdata);

	// **************************************************
	// transaction walk
	// **************************************************
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= i2c_pkg::seq_idle;
			op        <= '0;
			op_start  <= 1'b0;
			cnt       <= '0;
			clear     <= 1'b0;
			xfer_done <= 1'b0;
			xfer_nack <= 1'b0;
		end
		else
		begin
			op_start  <= 1'b0;
			clear     <= 1'b0;
			xfer_done <= 1'b0;
			if (op_done && send_state && rsp.nack)
			begin
				// slave refused, close the bus
				state     <= i2c_pkg::seq_stop;
				op        <= make_op(i2c_pkg::op_stop, 8'h00, 1'b1);
				op_start  <= 1'b1;
				xfer_nack <= 1'b1;
			end
			else
			begin
				case (state)
					i2c_pkg::seq_idle:
						if (req_valid)
						begin
							state     <= i2c_pkg::seq_start;
							op        <= make_op(i2c_pkg::op_start, 8'h00, 1'b1);
							op_start  <= 1'b1;
							xfer_nack <= 1'b0;
							clear     <= req.is_read;
						end
					i2c_pkg::seq_start:
						if (op_done)
						begin
							state    <= i2c_pkg::seq_dev_w;
							op       <= make_op(i2c_pkg::op_send, {req.dev_id, 1'b0}, 1'b1);
							op_start <= 1'b1;
						end
					i2c_pkg::seq_dev_w:
						if (op_done)
						begin
							state    <= i2c_pkg::seq_word;
							op       <= make_op(i2c_pkg::op_send, req.word_addr, 1'b1);
							op_start <= 1'b1;
						end
					i2c_pkg::seq_word:
						if (op_done)
						begin
							op_start <= 1'b1;
							if (req.is_read)
							begin
								state <= i2c_pkg::seq_restart;  // repeated start
								op    <= make_op(i2c_pkg::op_start, 8'h00, 1'b1);
							end
							else
							begin
								state <= i2c_pkg::seq_wdata;
								cnt   <= req.count - 3'd1;
								op    <= make_op(i2c_pkg::op_send, wr_byte, 1'b1);
							end
						end
					i2c_pkg::seq_wdata:
						if (op_done)
						begin
							op_start <= 1'b1;
							if (cnt == 3'd0)
							begin
								state <= i2c_pkg::seq_stop;
								op    <= make_op(i2c_pkg::op_stop, 8'h00, 1'b1);
							end
							else
							begin
								cnt <= cnt - 3'd1;
								op  <= make_op(i2c_pkg::op_send, wr_byte, 1'b1);
							end
						end
					i2c_pkg::seq_restart:
						if (op_done)
						begin
							state    <= i2c_pkg::seq_dev_r;
							op       <= make_op(i2c_pkg::op_send, {req.dev_id, 1'b1}, 1'b1);
							op_start <= 1'b1;
						end
					i2c_pkg::seq_dev_r:
						if (op_done)
						begin
							state    <= i2c_pkg::seq_rdata;
							cnt      <= req.count - 3'd1;
							op       <= make_op(i2c_pkg::op_recv, 8'h00, req.count == 3'd1);
							op_start <= 1'b1;
						end
					i2c_pkg::seq_rdata:
						if (op_done)
						begin
							op_start <= 1'b1;
							if (cnt == 3'd0)
							begin
								state <= i2c_pkg::seq_stop;
								op    <= make_op(i2c_pkg::op_stop, 8'h00, 1'b1);
							end
							else
							begin
								cnt <= cnt - 3'd1;
								op  <= make_op(i2c_pkg::op_recv, 8'h00, cnt == 3'd1);  // nack last
							end
						end
					i2c_pkg::seq_stop:
						if (op_done)
						begin
							state     <= i2c_pkg::seq_idle;
							xfer_done <= 1'b1;
						end
					default:
						state <= i2c_pkg::seq_idle;
				endcase
			end
		end
	end

endmodule

// File: hdl/i2c_cmd_stage.sv
// I2C command capture
`include "i2c_cfg.svh"

module i2c_cmd_stage (
	input  logic                   clk,
	input  logic                   rst_n,
	input  i2c_pkg::i2c_cmd_t      command,
	input  i2c_pkg::i2c_dev_id_t   dev_id,
	input  i2c_pkg::i2c_byte_t     word_addr,
	input  i2c_pkg::i2c_payload_t  wdata,
	input  i2c_pkg::i2c_count_t    byte_cnt,
	input  logic                   write_protect,
	input  logic                   xfer_done,
	input  logic                   xfer_nack,
	output i2c_pkg::i2c_req_t      req,
	output logic                   req_valid,
	output logic                   busy,
	output logic                   fail
);

	logic                cmd_seen;
	logic                wp_reject;
	logic                accept;
	i2c_pkg::i2c_count_t cnt_fix;

	assign cmd_seen  = !busy && (command != 2'b00);
	assign wp_reject = cmd_seen && command[1] && write_protect;  // write wins over read
	assign accept    = cmd_seen && !wp_reject;

	// keep the count inside 1..max
	assign cnt_fix = (byte_cnt == 3'd0) ? 3'd1 :
		(byte_cnt > 3'(`I2C_MAX_BYTES)) ? 3'(`I2C_MAX_BYTES) : byte_cnt;

	always_ff @(posedge clk)
	begin
		if (accept)
			req <= '{is_read: !command[1], dev_id: dev_id, word_addr: word_addr,
				count: cnt_fix, wdata: wdata};
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy      <= 1'b0;
			fail      <= 1'b0;
			req_valid <= 1'b0;
		end
		else
		begin
			req_valid <= accept;
			if (wp_reject)
				fail <= 1'b1;   // no bus activity at all
			else if (accept)
			begin
				busy <= 1'b1;
				fail <= 1'b0;
			end
			else if (busy && xfer_done)
			begin
				busy <= 1'b0;
				fail <= xfer_nack;
			end
		end
	end

endmodule

// File: hdl/i2c_pkg.sv
// I2C master shared types
`include "i2c_cfg.svh"

package i2c_pkg;

	typedef logic [7:0] i2c_byte_t;                     // one bus byte
	typedef logic [6:0] i2c_dev_id_t;                   // 7-bit slave address
	typedef logic [2:0] i2c_count_t;                    // bytes per transfer, 1..6
	typedef logic [`I2C_PAYLOAD_W-1:0] i2c_payload_t;   // byte 0 in bits 7:0
	typedef logic [1:0] i2c_cmd_t;                      // bit 1 write, bit 0 read

	typedef enum logic [1:0] {op_start, op_stop, op_send, op_recv} i2c_op_e;

	// accepted transfer, held while busy
	typedef struct packed {
		logic         is_read;
		i2c_dev_id_t  dev_id;
		i2c_byte_t    word_addr;
		i2c_count_t   count;
		i2c_payload_t wdata;
	} i2c_req_t;

	// one bus operation for the bit engine
	typedef struct packed {
		i2c_op_e   op;
		i2c_byte_t data;     // byte to send
		logic      ack_out;  // SDA level in the ack slot of a receive
	} i2c_op_t;

	typedef struct packed {
		logic      nack;     // ack slot sampled high
		i2c_byte_t rx_byte;
	} i2c_op_rsp_t;

	typedef enum logic [3:0] {
		seq_idle, seq_start, seq_dev_w, seq_word, seq_wdata,
		seq_restart, seq_dev_r, seq_rdata, seq_stop
	} i2c_seq_state_e;

	typedef enum logic [3:0] {
		ph_idle, ph_start_a, ph_start_b, ph_stop_a, ph_stop_b,
		ph_bit_lo, ph_bit_hi, ph_ack_lo, ph_ack_hi
	} i2c_bit_phase_e;

endpackage

// File: include/i2c_cfg.svh
// I2C master build config
`ifndef I2C_CFG_SVH
`define I2C_CFG_SVH

// **************************************************
// bus timing
// **************************************************

// clk cycles per SCL half period
`define I2C_TICK_DIV 8

// **************************************************
// transfer sizes
// **************************************************

`define I2C_MAX_BYTES 6   // longest burst
`define I2C_PAYLOAD_W 48  // 8 * I2C_MAX_BYTES

`endif
